// File: hdl/decode_unit.sv
// Decode stage of the tile
// Pops the buffer unless stalled, splits instruction fields
// Flags undefined opcodes and registers the result toward execute

`default_nettype none

module decode_unit (
	input  logic                clock,
	input  logic                reset,
	input  logic                empty,
	input  logic                stall,
	input  tpu_pkg::buf_entry_t head,
	output logic                pop,
	exec_if.producer            ex
);
	import tpu_pkg::*;

	decoded_t dec;

	assign pop = !empty && !stall;

	always_comb begin
		dec.opcode = opcode_t'(head.instr.opcode);
		dec.rd     = head.instr.rd;
		dec.ra     = head.instr.ra;
		dec.rb     = head.instr.rb;
		dec.imm    = head.instr.imm;
		dec.thread = head.thread;
		dec.issue  = head.issue;
		case (head.instr.opcode)
			OP_NOP, OP_LDI, OP_ADD, OP_SUB,
			OP_AND, OP_XOR, OP_OUT, OP_END: dec.illegal = 1'b0;
			default:                        dec.illegal = 1'b1;    // Codes 8 to 15
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			ex.valid <= 1'b0;
		end else begin
			ex.valid <= pop;
		end
	end

	always_ff @(posedge clock) begin
		if (pop) ex.dec <= dec;
	end

endmodule

`default_nettype wire

// File: hdl/execute_unit.sv
// Execute stage of the tile
// Eight-entry register file and 16-bit ALU
// Forwards OUT values, end markers and illegal instructions as results

`default_nettype none

module execute_unit (
	input  logic        clock,
	input  logic        reset,
	exec_if.consumer    ex,
	result_if.producer  res
);
	import tpu_pkg::*;

	data_t regs [NUM_REGS];
	data_t src_a;
	data_t src_b;
	data_t wr_val;
	logic  wr_en;
	logic  legal;

	assign legal = ex.valid && !ex.dec.illegal;
	assign src_a = regs[ex.dec.ra];
	assign src_b = regs[ex.dec.rb];

	//////////////////////////////////////////////////
	// ALU
	//////////////////////////////////////////////////

	always_comb begin
		wr_en  = 1'b0;
		wr_val = '0;
		if (legal) begin
			case (ex.dec.opcode)
				OP_LDI: begin
					wr_en  = 1'b1;
					wr_val = data_t'(ex.dec.imm);   // Zero extend
				end
				OP_ADD: begin
					wr_en  = 1'b1;
					wr_val = src_a + src_b;         // Wraps at 16 bits
				end
				OP_SUB: begin
					wr_en  = 1'b1;
					wr_val = src_a - src_b;
				end
				OP_AND: begin
					wr_en  = 1'b1;
					wr_val = src_a & src_b;
				end
				OP_XOR: begin
					wr_en  = 1'b1;
					wr_val = src_a ^ src_b;
				end
				default: wr_en = 1'b0;             // NOP, OUT, END write nothing
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < NUM_REGS; i++) regs[i] <= '0;
		end else if (wr_en) begin
			regs[ex.dec.rd] <= wr_val;
		end
	end

	//////////////////////////////////////////////////
	// Result stage register
	//////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			res.valid      <= 1'b0;
			res.is_out     <= 1'b0;
			res.is_end     <= 1'b0;
			res.is_illegal <= 1'b0;
		end else begin
			res.valid      <= ex.valid;
			res.is_out     <= legal && ex.dec.opcode == OP_OUT;
			res.is_end     <= legal && ex.dec.opcode == OP_END;
			res.is_illegal <= ex.valid && ex.dec.illegal;
		end
	end

	always_ff @(posedge clock) begin
		if (ex.valid) begin
			res.value  <= src_a;    // Register ra for OUT
			res.thread <= ex.dec.thread;
			res.issue  <= ex.dec.issue;
		end
	end

endmodule

`default_nettype wire

// File: hdl/front_end.sv
// Job sequencer of the tile
// Registers host inputs, steps issue/thread/instruction states
// Writes instructions and end markers into the buffer, nacks on full

`default_nettype none

module front_end (
	input  logic                clock,
	input  logic                reset,
	input  logic                word_valid,
	input  tpu_pkg::word_t      word,
	input  logic                term,
	input  logic                buf_full,
	output logic                buf_we,
	output tpu_pkg::buf_entry_t buf_entry,
	output logic                nack
);
	import tpu_pkg::*;

	logic       word_valid_q;
	logic       term_q;
	word_t      word_q;
	fe_state_t  state;
	issue_no_t  issue_q;        // Current job issue number
	thread_id_t thread_q;       // Current job thread ID
	logic       want_write;

	//////////////////////////////////////////////////
	// Input registers
	//////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			word_valid_q <= 1'b0;
			term_q       <= 1'b0;
		end else begin
			word_valid_q <= word_valid;
			term_q       <= term;
		end
	end

	always_ff @(posedge clock) begin
		word_q <= word;
	end

	//////////////////////////////////////////////////
	// Job state
	//////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= FE_ISSUE;
		end else begin
			case (state)
				FE_ISSUE: begin
					if (word_valid_q) state <= FE_THREAD;
				end
				FE_THREAD: begin
					if (word_valid_q) state <= FE_INSTR;
				end
				FE_INSTR: begin
					if (term_q && !buf_full) state <= FE_ISSUE;   // Dropped term keeps the job open
				end
				default: state <= FE_ISSUE;
			endcase
		end
	end

	// Header values from the low bits of the header words
	always_ff @(posedge clock) begin
		if (state == FE_ISSUE && word_valid_q) issue_q <= word_q[7:0];
		if (state == FE_THREAD && word_valid_q) thread_q <= word_q[3:0];
	end

	//////////////////////////////////////////////////
	// Buffer write and nack
	//////////////////////////////////////////////////

	// Term wins over a word in the same cycle
	assign want_write = (state == FE_INSTR) && (word_valid_q || term_q);
	assign buf_we     = want_write && !buf_full;

	// End marker has all other fields zero
	assign buf_entry.instr  = term_q ? instr_t'({OP_END, 20'd0}) : instr_t'(word_q);
	assign buf_entry.thread = thread_q;
	assign buf_entry.issue  = issue_q;

	always_ff @(posedge clock) begin
		if (reset) begin
			nack <= 1'b0;
		end else begin
			nack <= want_write && buf_full;   // Word or term dropped
		end
	end

endmodule

`default_nettype wire

// File: hdl/instr_buffer.sv
// Instruction FIFO of the tile
// Circular buffer of tagged entries with show-ahead head output
// Full and empty come straight from the entry count

`default_nettype none

module instr_buffer (
	input  logic                clock,
	input  logic                reset,
	input  logic                we,
	input  tpu_pkg::buf_entry_t wr_entry,
	output logic                full,
	output logic                empty,
	input  logic                pop,
	output tpu_pkg::buf_entry_t head
);
	import tpu_pkg::*;

	buf_entry_t           mem [BUF_DEPTH];
	logic [BUF_PTR_W-1:0] wr_ptr;
	logic [BUF_PTR_W-1:0] rd_ptr;
	logic [BUF_CNT_W-1:0] count;

	assign full  = (count == BUF_CNT_W'(BUF_DEPTH));
	assign empty = (count == '0);
	assign head  = mem[rd_ptr];     // Valid while not empty

	always_ff @(posedge clock) begin
		if (we) mem[wr_ptr] <= wr_entry;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (we) wr_ptr <= wr_ptr + 1'b1;    // Wraps, depth is a power of two
			if (pop) rd_ptr <= rd_ptr + 1'b1;
			case ({we, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	a_no_pop_empty: assert property (@(posedge clock) disable iff (reset)
		pop |-> !empty);

	a_no_write_full: assert property (@(posedge clock) disable iff (reset)
		we |-> !full);

endmodule

`default_nettype wire

// File: hdl/result_unit.sv
// Result stage of the tile
// OUT pulses with thread and issue, job done pulses
// Saturating count of illegal instructions

`default_nettype none

module result_unit (
	input  logic                  clock,
	input  logic                  reset,
	result_if.consumer            res,
	output logic                  out_valid,
	output tpu_pkg::data_t        out_value,
	output tpu_pkg::thread_id_t   out_thread,
	output tpu_pkg::issue_no_t    out_issue,
	output logic                  done,
	output tpu_pkg::issue_no_t    done_issue,
	output logic [7:0]            illegal_count
);
	import tpu_pkg::*;

	always_ff @(posedge clock) begin
		if (reset) begin
			out_valid     <= 1'b0;
			done          <= 1'b0;
			illegal_count <= '0;
		end else begin
			out_valid <= res.valid && res.is_out;
			done      <= res.valid && res.is_end;
			if (res.valid && res.is_illegal && illegal_count != 8'hff)
				illegal_count <= illegal_count + 8'd1;  // Saturates at 255
		end
	end

	always_ff @(posedge clock) begin
		if (res.valid && res.is_out) begin
			out_value  <= res.value;
			out_thread <= res.thread;
			out_issue  <= res.issue;
		end
		if (res.valid && res.is_end) done_issue <= res.issue;
	end

	a_one_kind: assert property (@(posedge clock) disable iff (reset)
		res.valid |-> $onehot0({res.is_out, res.is_end, res.is_illegal}));

endmodule

`default_nettype wire

// File: hdl/tpu_if.sv
// Stage interfaces of the tile
// exec_if from decode to execute
// result_if from execute to result

`default_nettype none

interface exec_if;
	import tpu_pkg::*;

	logic     valid;    // One decoded instruction this cycle
	decoded_t dec;      // Fields, thread and issue

	modport producer (output valid, dec);
	modport consumer (input valid, dec);
endinterface

interface result_if;
	import tpu_pkg::*;

	logic       valid;      // One instruction retired
	logic       is_out;
	logic       is_end;
	logic       is_illegal;
	data_t      value;      // Register ra for OUT
	thread_id_t thread;
	issue_no_t  issue;

	modport producer (output valid, is_out, is_end, is_illegal, value, thread, issue);
	modport consumer (input valid, is_out, is_end, is_illegal, value, thread, issue);
endinterface

`default_nettype wire

// File: hdl/tpu_pkg.sv
// Shared types for the thread-processing tile
// Word, issue, thread, data and register index types
// Opcode and front end state enums
// Buffer entry and decoded instruction structs, buffer and register file sizes

`default_nettype none

package tpu_pkg;

	localparam int BUF_DEPTH = 8;                 // Instruction buffer entries
	localparam int BUF_PTR_W = $clog2(BUF_DEPTH);
	localparam int BUF_CNT_W = $clog2(BUF_DEPTH + 1);
	localparam int NUM_REGS  = 8;                 // Register file entries

	typedef logic [23:0] word_t;        // Host word
	typedef logic [7:0]  issue_no_t;    // Job issue number
	typedef logic [3:0]  thread_id_t;   // Thread ID
	typedef logic [15:0] data_t;        // Register width
	typedef logic [2:0]  reg_idx_t;     // Register index

	typedef enum logic [3:0] {
		OP_NOP = 4'd0,
		OP_LDI = 4'd1,  // rd = zero-extended imm
		OP_ADD = 4'd2,
		OP_SUB = 4'd3,
		OP_AND = 4'd4,
		OP_XOR = 4'd5,
		OP_OUT = 4'd6,  // Emit register ra
		OP_END = 4'd7   // Job end marker, inserted on term
	} opcode_t;

	typedef enum logic [1:0] {
		FE_ISSUE,       // Waiting for the issue number word
		FE_THREAD,      // Waiting for the thread ID word
		FE_INSTR        // Instruction words until term
	} fe_state_t;

	// Raw opcode field, undefined codes survive until decode
	typedef struct packed {
		logic [3:0]  opcode;
		reg_idx_t    rd;
		reg_idx_t    ra;
		reg_idx_t    rb;
		logic [10:0] imm;
	} instr_t;

	typedef struct packed {
		instr_t     instr;
		thread_id_t thread;
		issue_no_t  issue;
	} buf_entry_t;

	typedef struct packed {
		opcode_t     opcode;
		reg_idx_t    rd;
		reg_idx_t    ra;
		reg_idx_t    rb;
		logic [10:0] imm;
		thread_id_t  thread;
		issue_no_t   issue;
		logic        illegal;   // Undefined opcode
	} decoded_t;

endpackage

`default_nettype wire

// File: hdl/tpu_top.sv
// Top level of the thread-processing tile
// Front end, instruction buffer, decode, execute and result stages

`default_nettype none

module tpu_top (
	input  logic                clock,
	input  logic                reset,
	input  logic                word_valid,
	input  tpu_pkg::word_t      word,
	input  logic                term,
	input  logic                stall,
	output logic                nack,
	output logic                out_valid,
	output tpu_pkg::data_t      out_value,
	output tpu_pkg::thread_id_t out_thread,
	output tpu_pkg::issue_no_t  out_issue,
	output logic                done,
	output tpu_pkg::issue_no_t  done_issue,
	output logic [7:0]          illegal_count
);
	import tpu_pkg::*;

	logic       buf_we;
	logic       buf_full;
	logic       buf_empty;
	logic       buf_pop;
	buf_entry_t buf_wr_entry;
	buf_entry_t buf_head;

	exec_if   ex_bus ();
	result_if res_bus ();

	front_end front_end_i (
		.clock      (clock),
		.reset      (reset),
		.word_valid (word_valid),
		.word       (word),
		.term       (term),
		.buf_full   (buf_full),
		.buf_we     (buf_we),
		.buf_entry  (buf_wr_entry),
		.nack       (nack)
	);

	instr_buffer instr_buffer_i (
		.clock    (clock),
		.reset    (reset),
		.we       (buf_we),
		.wr_entry (buf_wr_entry),
		.full     (buf_full),
		.empty    (buf_empty),
		.pop      (buf_pop),
		.head     (buf_head)
	);

	decode_unit decode_unit_i (
		.clock (clock),
		.reset (reset),
		.empty (buf_empty),
		.stall (stall),
		.head  (buf_head),
		.pop   (buf_pop),
		.ex    (ex_bus.producer)
	);

	execute_unit execute_unit_i (
		.clock (clock),
		.reset (reset),
		.ex    (ex_bus.consumer),
		.res   (res_bus.producer)
	);

	result_unit result_unit_i (
		.clock         (clock),
		.reset         (reset),
		.res           (res_bus.consumer),
		.out_valid     (out_valid),
		.out_value     (out_value),
		.out_thread    (out_thread),
		.out_issue     (out_issue),
		.done          (done),
		.done_issue    (done_issue),
		.illegal_count (illegal_count)
	);

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and search the output for the pass message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_tpu -f sources.f -o tb_tpu_sim \
	&& ./obj_dir/tb_tpu_sim | tee /dev/stderr | grep -F '*** TEST PASSED ***' > /dev/null \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

// File: sources.f
hdl/tpu_pkg.sv
hdl/tpu_if.sv
hdl/front_end.sv
hdl/instr_buffer.sv
hdl/decode_unit.sv
hdl/execute_unit.sv
hdl/result_unit.sv
hdl/tpu_top.sv
tests/tb_clock.sv
tests/tb_tpu.sv

// File: tests/tb_clock.sv
// Testbench clock and reset source
// Clock period 4, reset high for the first 4 cycles

`default_nettype none

module tb_clock (
	output logic clock,
	output logic reset
);
	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	initial begin
		reset = 1'b1;
		repeat (4) @(posedge clock);
		#1 reset = 1'b0;      // Released just after the 4th edge
	end
endmodule

`default_nettype wire

// File: tests/tb_tpu.sv
// Testbench for the thread-processing tile
// Stimulus list, reference model, compare process and timeout
// Tests: reset idle, single job, ALU mix, back-to-back jobs, stall burst, illegal opcodes

`default_nettype none

module tb_tpu;
	import tpu_pkg::*;

	localparam logic [3:0] C_NOP = 4'd0;
	localparam logic [3:0] C_LDI = 4'd1;
	localparam logic [3:0] C_ADD = 4'd2;
	localparam logic [3:0] C_SUB = 4'd3;
	localparam logic [3:0] C_AND = 4'd4;
	localparam logic [3:0] C_XOR = 4'd5;
	localparam logic [3:0] C_OUT = 4'd6;
	localparam int DEPTH           = 8;    // Buffer entries
	localparam int CYCLES_PER_WORD = 40;
	localparam int BASE_CYCLES     = 200;

	typedef enum logic [1:0] {S_WORD, S_TERM, S_STALL_ON, S_STALL_OFF} stim_kind_t;

	typedef struct packed {
		stim_kind_t kind;
		word_t      word;
	} stim_t;

	typedef struct packed {
		data_t      value;
		thread_id_t thread;
		issue_no_t  issue;
	} out_t;

	logic       clock;
	logic       reset;
	logic       word_valid;
	word_t      word;
	logic       term;
	logic       stall;
	logic       nack;
	logic       out_valid;
	data_t      out_value;
	thread_id_t out_thread;
	issue_no_t  out_issue;
	logic       done;
	issue_no_t  done_issue;
	logic [7:0] illegal_count;

	stim_t      stim_q[$];
	out_t       exp_out_q[$];
	issue_no_t  exp_done_q[$];
	int         out_rd;         // Next expected OUT for the compare process
	int         done_rd;
	int         out_seen;
	int         done_seen;
	int         nack_seen;
	int         cmp_errors;
	int         cmp_checks;
	int         errors;
	int         checks;
	int         err_base;
	int         tests;
	int         failed;
	int         sent_words;
	int         cycles;
	int         limit = BASE_CYCLES;
	integer     seed = 32'hb69e;

	// Model state kept across jobs like the register file
	data_t      m_regs [8];
	int         m_state;        // 0 issue, 1 thread, 2 instructions
	issue_no_t  m_issue;
	thread_id_t m_thread;
	logic       m_stalled;
	int         m_held;         // Entries written since stall went high
	logic [7:0] m_illegal;
	int         m_nacks;

	tb_clock clock_gen (
		.clock (clock),
		.reset (reset)
	);

	tpu_top tpu_top_i (
		.clock         (clock),
		.reset         (reset),
		.word_valid    (word_valid),
		.word          (word),
		.term          (term),
		.stall         (stall),
		.nack          (nack),
		.out_valid     (out_valid),
		.out_value     (out_value),
		.out_thread    (out_thread),
		.out_issue     (out_issue),
		.done          (done),
		.done_issue    (done_issue),
		.illegal_count (illegal_count)
	);

	//////////////////////////////////////////////////
	// Compare tasks
	//////////////////////////////////////////////////

	task automatic check_out(input data_t exp_value, input thread_id_t exp_thread,
		input issue_no_t exp_issue, input data_t got_value, input thread_id_t got_thread,
		input issue_no_t got_issue);
		cmp_checks++;
		if (exp_value !== got_value) begin
			cmp_errors++;
			$display("Fail out_value exp %h got %h", exp_value, got_value);
		end
		if (exp_thread !== got_thread) begin
			cmp_errors++;
			$display("Fail out_thread exp %h got %h", exp_thread, got_thread);
		end
		if (exp_issue !== got_issue) begin
			cmp_errors++;
			$display("Fail out_issue exp %h got %h", exp_issue, got_issue);
		end
	endtask

	task automatic check_done(input issue_no_t exp_issue, input issue_no_t got_issue);
		cmp_checks++;
		if (exp_issue !== got_issue) begin
			cmp_errors++;
			$display("Fail done_issue exp %h got %h", exp_issue, got_issue);
		end
	endtask

	task automatic check_count(input string name, input logic [7:0] exp, input logic [7:0] got);
		checks++;
		if (exp !== got) begin
			errors++;
			$display("Fail %s exp %h got %h", name, exp, got);
		end
	endtask

	// Result compare on the falling edge
	always @(negedge clock) begin
		if (!reset && out_valid) begin
			out_seen++;
			if (out_rd >= exp_out_q.size()) begin
				cmp_errors++;
				$display("Unexpected OUT result %h while none was pending", out_value);
			end else begin
				check_out(exp_out_q[out_rd].value, exp_out_q[out_rd].thread,
					exp_out_q[out_rd].issue, out_value, out_thread, out_issue);
				out_rd++;
			end
		end
		if (!reset && done) begin
			done_seen++;
			if (done_rd >= exp_done_q.size()) begin
				cmp_errors++;
				$display("Unexpected done for issue %h while no job was open", done_issue);
			end else begin
				check_done(exp_done_q[done_rd], done_issue);
				done_rd++;
			end
		end
		if (!reset && nack) nack_seen++;
	end

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////

	function automatic void model_exec(input instr_t ins);
		out_t o;
		case (ins.opcode)
			C_NOP: ;
			C_LDI: m_regs[ins.rd] = data_t'(ins.imm);
			C_ADD: m_regs[ins.rd] = m_regs[ins.ra] + m_regs[ins.rb];   // 16-bit wrap
			C_SUB: m_regs[ins.rd] = m_regs[ins.ra] - m_regs[ins.rb];
			C_AND: m_regs[ins.rd] = m_regs[ins.ra] & m_regs[ins.rb];
			C_XOR: m_regs[ins.rd] = m_regs[ins.ra] ^ m_regs[ins.rb];
			C_OUT: begin
				o.value  = m_regs[ins.ra];
				o.thread = m_thread;
				o.issue  = m_issue;
				exp_out_q.push_back(o);
			end
			default: begin
				if (m_illegal != 8'hff) m_illegal = m_illegal + 8'd1;   // Saturating
			end
		endcase
	endfunction

	// Walks the current stimulus list in order
	function automatic void model_run();
		stim_t s;
		logic  accept;
		for (int n = 0; n < stim_q.size(); n++) begin
			s      = stim_q[n];
			accept = !(m_stalled && m_held >= DEPTH);    // Buffer full while stalled
			case (s.kind)
				S_STALL_ON: begin
					m_stalled = 1'b1;
					m_held    = 0;
				end
				S_STALL_OFF: m_stalled = 1'b0;
				S_WORD: begin
					if (m_state == 0) begin
						m_issue = s.word[7:0];
						m_state = 1;
					end else if (m_state == 1) begin
						m_thread = s.word[3:0];
						m_state  = 2;
					end else if (!accept) begin
						m_nacks++;
					end else begin
						m_held++;
						model_exec(instr_t'(s.word));
					end
				end
				default: begin
					if (m_state == 2 && !accept) begin
						m_nacks++;                      // Job stays open
					end else if (m_state == 2) begin
						m_held++;
						exp_done_q.push_back(m_issue);
						m_state = 0;
					end
				end
			endcase
		end
	endfunction

	//////////////////////////////////////////////////
	// Stimulus helpers
	//////////////////////////////////////////////////

	function automatic word_t encode_instr(input logic [3:0] op, input reg_idx_t rd,
		input reg_idx_t ra, input reg_idx_t rb, input logic [10:0] imm);
		instr_t i;
		i.opcode = op;
		i.rd     = rd;
		i.ra     = ra;
		i.rb     = rb;
		i.imm    = imm;
		return word_t'(i);
	endfunction

	task automatic add_word(input word_t w);
		stim_t s;
		s.kind = S_WORD;
		s.word = w;
		stim_q.push_back(s);
		sent_words++;
	endtask

	task automatic add_term();
		stim_t s;
		s.kind = S_TERM;
		s.word = '0;
		stim_q.push_back(s);
		sent_words++;
	endtask

	task automatic stall_step(input logic level);
		stim_t s;
		s.kind = level ? S_STALL_ON : S_STALL_OFF;
		s.word = '0;
		stim_q.push_back(s);
	endtask

	// Random upper bits around the header field
	task automatic job_header(input issue_no_t iss, input thread_id_t thr);
		word_t w;
		w = word_t'($random(seed));
		add_word({w[23:8], iss});
		w = word_t'($random(seed));
		add_word({w[23:4], thr});
	endtask

	task automatic drive_stim();
		model_run();
		limit = BASE_CYCLES + CYCLES_PER_WORD * sent_words;
		foreach (stim_q[n]) begin
			@(posedge clock);
			#1;
			word_valid = 1'b0;
			term       = 1'b0;
			case (stim_q[n].kind)
				S_WORD: begin
					word_valid = 1'b1;
					word       = stim_q[n].word;
				end
				S_TERM:     term  = 1'b1;
				S_STALL_ON: stall = 1'b1;
				default:    stall = 1'b0;
			endcase
		end
		@(posedge clock);
		#1;
		word_valid = 1'b0;
		term       = 1'b0;
	endtask

	task automatic start_case();
		stim_q.delete();
		err_base = errors + cmp_errors;
	endtask

	task automatic wait_and_report(input string name);
		while (out_rd < exp_out_q.size() || done_rd < exp_done_q.size())
			@(posedge clock);
		repeat (8) @(posedge clock);    // Room for stray results
		#1;
		check_count("illegal_count", m_illegal, illegal_count);
		check_count("nack", 8'(m_nacks), 8'(nack_seen));
		tests++;
		if (errors + cmp_errors == err_base) begin
			$display("test %0d %s: ok", tests, name);
		end else begin
			failed++;
			$display("test %0d %s: FAILED", tests, name);
		end
	endtask

	//////////////////////////////////////////////////
	// Tests
	//////////////////////////////////////////////////

	task automatic reset_idle();
		start_case();
		repeat (10) @(posedge clock);
		#1;
		check_count("out_valid", 8'd0, 8'(out_seen));
		check_count("done", 8'd0, 8'(done_seen));
		check_count("nack", 8'd0, 8'(nack_seen));
		wait_and_report("reset_idle");
	endtask

	task automatic single_job();
		start_case();
		job_header(8'h11, 4'h3);
		add_word(encode_instr(C_LDI, 3'd1, 3'd0, 3'd0, 11'h123));
		add_word(encode_instr(C_LDI, 3'd2, 3'd0, 3'd0, 11'h7ff));
		add_word(encode_instr(C_OUT, 3'd0, 3'd1, 3'd0, 11'd0));
		add_word(encode_instr(C_OUT, 3'd0, 3'd2, 3'd0, 11'd0));
		add_word(encode_instr(C_NOP, 3'd5, 3'd5, 3'd5, 11'h0aa));
		add_term();
		drive_stim();
		wait_and_report("single_job");
	endtask

	task automatic alu_mix();
		start_case();
		job_header(8'h22, 4'h5);
		for (int r = 0; r < 6; r++) begin
			add_word(encode_instr(C_LDI, 3'd1, 3'd0, 3'd0, 11'($random(seed))));
			add_word(encode_instr(C_LDI, 3'd2, 3'd0, 3'd0, 11'($random(seed))));
			add_word(encode_instr(C_ADD, 3'd3, 3'd1, 3'd2, 11'd0));
			add_word(encode_instr(C_OUT, 3'd0, 3'd3, 3'd0, 11'd0));
			add_word(encode_instr(C_SUB, 3'd4, 3'd1, 3'd2, 11'd0));   // Often negative
			add_word(encode_instr(C_OUT, 3'd0, 3'd4, 3'd0, 11'd0));
			add_word(encode_instr(C_AND, 3'd5, 3'd4, 3'd3, 11'd0));
			add_word(encode_instr(C_OUT, 3'd0, 3'd5, 3'd0, 11'd0));
			add_word(encode_instr(C_XOR, 3'd6, 3'd4, 3'd6, 11'd0));
			add_word(encode_instr(C_OUT, 3'd0, 3'd6, 3'd0, 11'd0));
			add_word(encode_instr(C_ADD, 3'd7, 3'd4, 3'd4, 11'd0));   // Carries out when negative
			add_word(encode_instr(C_OUT, 3'd0, 3'd7, 3'd0, 11'd0));
		end
		add_term();
		drive_stim();
		wait_and_report("alu_mix");
	endtask

	task automatic back_to_back();
		start_case();
		job_header(8'h40, 4'h9);
		add_word(encode_instr(C_LDI, 3'd7, 3'd0, 3'd0, 11'h2aa));
		add_word(encode_instr(C_OUT, 3'd0, 3'd7, 3'd0, 11'd0));
		add_word(encode_instr(C_OUT, 3'd0, 3'd6, 3'd0, 11'd0));   // Left by the ALU test
		add_term();
		add_term();                                                // Ignored in the header state
		job_header(8'h41, 4'he);
		add_word(encode_instr(C_OUT, 3'd0, 3'd7, 3'd0, 11'd0));
		add_word(encode_instr(C_ADD, 3'd7, 3'd7, 3'd7, 11'd0));
		add_word(encode_instr(C_OUT, 3'd0, 3'd7, 3'd0, 11'd0));
		add_term();
		drive_stim();
		wait_and_report("back_to_back");
	endtask

	task automatic stall_burst();
		start_case();
		stall_step(1'b1);
		job_header(8'h60, 4'h2);
		for (int i = 0; i < 12; i++) begin
			if (i % 2 == 0)
				add_word(encode_instr(C_LDI, 3'd0, 3'd0, 3'd0, 11'(i * 37 + 5)));
			else
				add_word(encode_instr(C_OUT, 3'd0, 3'd0, 3'd0, 11'd0));
		end
		stall_step(1'b0);
		add_term();
		drive_stim();
		wait_and_report("stall_burst");
	endtask

	task automatic illegal_ops();
		word_t w;
		start_case();
		job_header(8'h77, 4'ha);
		add_word(encode_instr(C_LDI, 3'd2, 3'd0, 3'd0, 11'h005));
		add_word(encode_instr(4'h8, 3'd2, 3'd2, 3'd2, 11'h3ff));
		add_word(encode_instr(C_OUT, 3'd0, 3'd2, 3'd0, 11'd0));
		for (int i = 0; i < 3; i++) begin
			w = word_t'($random(seed));
			add_word({1'b1, w[22:0]});    // Opcode 8 to 15
		end
		add_word(encode_instr(C_NOP, 3'd0, 3'd0, 3'd0, 11'd0));
		add_word(encode_instr(C_OUT, 3'd0, 3'd2, 3'd0, 11'd0));
		add_term();
		drive_stim();
		wait_and_report("illegal_ops");
	endtask

	//////////////////////////////////////////////////
	// Run control
	//////////////////////////////////////////////////

	initial begin
		cycles = 0;
		while (cycles <= limit) begin
			@(posedge clock);
			cycles++;
		end
		$display("Timeout: the run did not finish within %0d cycles", limit);
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin
		word_valid = 1'b0;
		word       = '0;
		term       = 1'b0;
		stall      = 1'b0;
		for (int r = 0; r < 8; r++) m_regs[r] = '0;
		m_state   = 0;
		m_stalled = 1'b0;
		m_held    = 0;
		m_illegal = 8'd0;
		m_nacks   = 0;
		wait (reset === 1'b0);
		reset_idle();
		single_job();
		alu_mix();
		back_to_back();
		stall_burst();
		illegal_ops();
		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests, failed, checks + cmp_checks, errors + cmp_errors);
		if (errors + cmp_errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire
